// File: rtl/job_config.svh
`ifndef JOB_CONFIG_SVH
`define JOB_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Job interface widths
//////////////////////////////////////////////////////////////////////

// Effective address carried with each job command
`define JOB_ADDR_W 64
// Command code width
`define JOB_CMD_W 8

//////////////////////////////////////////////////////////////////////
// Command codes and buffer sizing
//////////////////////////////////////////////////////////////////////

// Host command codes
`define JOB_CMD_START 8'h90
`define JOB_CMD_RESET 8'h80

// Error record buffer entries
`define ERR_FIFO_DEPTH 4

`endif

// File: rtl/job_pkg.sv
`default_nettype none

`include "job_config.svh"

package job_pkg;

  // Job address as supplied by the host
  typedef logic [`JOB_ADDR_W-1:0] job_addr_t;

  // Job command code
  typedef logic [`JOB_CMD_W-1:0] job_cmd_t;

  // Parity error flags
  // Bit 1 is command parity, bit 0 is address parity
  typedef logic [1:0] err_bits_t;

  // Error report word returned with done
  typedef logic [63:0] report_t;

  // Decoded command
  typedef enum logic [1:0] {
    OP_START,
    OP_RESET,
    OP_OTHER
  } job_op_e;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    RUNNING,
    DONE_PEND
  } ctl_state_e;

endpackage

`default_nettype wire

// File: rtl/err_wr_if.sv
`default_nettype none

// Error records from the job controller into the buffer
interface err_wr_if;

  // One-cycle write strobe
  logic                push;
  // Command code of the failing job command
  job_pkg::job_cmd_t   cmd;
  // Which parity checks failed
  job_pkg::err_bits_t  errs;
  // Buffer has no free entry
  logic                full;

  // Controller side
  modport producer (
    output push, cmd, errs,
    input  full
  );

  // Buffer side
  modport buffer (
    input  push, cmd, errs,
    output full
  );

endinterface

`default_nettype wire

// File: rtl/err_rd_if.sv
`default_nettype none

// Error records from the buffer into the reporter
interface err_rd_if;

  // One-cycle read strobe, removes the head
  logic                pop;
  // No record available
  logic                empty;
  // Head record, valid while empty is low
  job_pkg::job_cmd_t   cmd;
  job_pkg::err_bits_t  errs;

  // Buffer side
  modport buffer (
    input  pop,
    output empty, cmd, errs
  );

  // Reporter side
  modport consumer (
    output pop,
    input  empty, cmd, errs
  );

endinterface

`default_nettype wire

// File: rtl/job_control.sv
`default_nettype none

`include "job_config.svh"

module job_control (
  input  logic                clock,
  input  logic                rstn,
  input  logic                job_valid,
  input  job_pkg::job_cmd_t   job_command,
  input  logic                job_command_parity,
  input  job_pkg::job_addr_t  job_address,
  input  logic                job_address_parity,
  input  job_pkg::report_t    report,
  err_wr_if.producer          err_wr,
  output logic                running,
  output logic                done,
  output logic                reset_job,
  output job_pkg::err_bits_t  job_errors,
  output job_pkg::report_t    error
);

  // Input latch, loaded at E0
  logic                latch_valid;
  job_pkg::job_cmd_t   latch_cmd;
  job_pkg::job_addr_t  latch_addr;
  logic                latch_cpar;
  logic                latch_apar;

  // Decode and parity stage, loaded at E1
  logic                dec_valid;
  job_pkg::job_op_e    dec_op;
  job_pkg::err_bits_t  dec_errs;
  job_pkg::job_cmd_t   dec_cmd;

  job_pkg::ctl_state_e state;

  function automatic job_pkg::job_op_e decode_op(input job_pkg::job_cmd_t c);
    case (c)
      `JOB_CMD_START: return job_pkg::OP_START;
      `JOB_CMD_RESET: return job_pkg::OP_RESET;
      default:        return job_pkg::OP_OTHER;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Command latch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      latch_valid <= 1'b0;
    end else begin
      latch_valid <= job_valid;
    end
  end

  // Payload only moves on a valid strobe
  always_ff @(posedge clock) begin
    if (job_valid) begin
      latch_cmd  <= job_command;
      latch_addr <= job_address;
      latch_cpar <= job_command_parity;
      latch_apar <= job_address_parity;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Decode and odd parity check
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= latch_valid;
    end
  end

  // Odd parity: data plus parity bit must hold an odd number of ones
  always_ff @(posedge clock) begin
    dec_op      <= decode_op(latch_cmd);
    dec_errs[1] <= ~^{latch_cmd, latch_cpar};
    dec_errs[0] <= ~^{latch_addr, latch_apar};
    dec_cmd     <= latch_cmd;
  end

  //////////////////////////////////////////////////////////////////////
  // Job control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state      <= job_pkg::IDLE;
      reset_job  <= 1'b0;
      done       <= 1'b0;
      error      <= '0;
      job_errors <= '0;
      err_wr.push <= 1'b0;
    end else begin
      // Strobes default low
      reset_job   <= 1'b0;
      done        <= 1'b0;
      error       <= '0;
      err_wr.push <= 1'b0;
      if (dec_valid) begin
        // Every command updates the error flags, E2
        job_errors  <= dec_errs;
        err_wr.push <= |dec_errs;
      end
      case (state)
        job_pkg::DONE_PEND: begin
          // E3, report sampled before the reporter clears
          done  <= 1'b1;
          error <= report;
          state <= job_pkg::IDLE;
        end
        default: begin
          if (dec_valid && dec_op == job_pkg::OP_START) begin
            state <= job_pkg::RUNNING;
          end else if (dec_valid && dec_op == job_pkg::OP_RESET) begin
            state     <= job_pkg::DONE_PEND;
            reset_job <= 1'b1;
          end
        end
      endcase
    end
  end

  // Record payload follows the push strobe
  always_ff @(posedge clock) begin
    if (dec_valid) begin
      err_wr.cmd  <= dec_cmd;
      err_wr.errs <= dec_errs;
    end
  end

  assign running = (state == job_pkg::RUNNING);

  // Done is a single-cycle pulse
  a_done_single : assert property (@(posedge clock) disable iff (!rstn)
    done |=> !done);

  // Buffer must have room whenever a record is pushed
  a_push_not_full : assert property (@(posedge clock) disable iff (!rstn)
    !(err_wr.push && err_wr.full));

endmodule

`default_nettype wire

// File: rtl/err_fifo.sv
`default_nettype none

`include "job_config.svh"

module err_fifo (
  input  logic  clock,
  input  logic  rstn,
  err_wr_if.buffer wr,
  err_rd_if.buffer rd
);

  localparam int PTR_W = $clog2(`ERR_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`ERR_FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`ERR_FIFO_DEPTH - 1);
  localparam logic [CNT_W:0]   DEPTH_V  = (CNT_W + 1)'(`ERR_FIFO_DEPTH);

  // Record storage
  job_pkg::job_cmd_t   cmd_mem  [`ERR_FIFO_DEPTH];
  job_pkg::err_bits_t  errs_mem [`ERR_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Entries visible to the read side
  logic [CNT_W-1:0] count;
  // Entry written last edge, visible from the next one
  logic             commit_q;
  logic [CNT_W:0]   occupancy;

  //////////////////////////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (wr.push) begin
      cmd_mem[wr_ptr]  <= wr.cmd;
      errs_mem[wr_ptr] <= wr.errs;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      commit_q <= 1'b0;
    end else begin
      commit_q <= wr.push;
      if (wr.push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (rd.pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Count only sees committed entries
      case ({commit_q, rd.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Flags and head
  //////////////////////////////////////////////////////////////////////

  // Memory occupancy includes the entry not yet committed
  assign occupancy = {1'b0, count} + {{CNT_W{1'b0}}, commit_q};
  assign wr.full   = (occupancy >= DEPTH_V);
  assign rd.empty  = (count == '0);
  assign rd.cmd    = cmd_mem[rd_ptr];
  assign rd.errs   = errs_mem[rd_ptr];

  // Reporter must not read a missing record
  a_no_pop_empty : assert property (@(posedge clock) disable iff (!rstn)
    rd.pop |-> !rd.empty);

endmodule

`default_nettype wire

// File: rtl/err_reporter.sv
`default_nettype none

module err_reporter (
  input  logic              clock,
  input  logic              rstn,
  err_rd_if.consumer        rd,
  input  logic              clear,
  output job_pkg::report_t  report
);

  // Saturating counters
  logic [7:0] total_cnt;
  logic [7:0] cmd_cnt;
  logic [7:0] addr_cnt;

  // First record since the last clear
  logic                seen;
  job_pkg::job_cmd_t   first_cmd;
  job_pkg::err_bits_t  first_errs;

  function automatic logic [7:0] sat_inc(input logic [7:0] v);
    return (v == 8'hFF) ? v : v + 8'd1;
  endfunction

  // Drain one record per cycle, hold off during a clear
  assign rd.pop = !rd.empty && !clear;

  //////////////////////////////////////////////////////////////////////
  // Counters and first-error capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      total_cnt  <= '0;
      cmd_cnt    <= '0;
      addr_cnt   <= '0;
      seen       <= 1'b0;
      first_cmd  <= '0;
      first_errs <= '0;
    end else if (clear) begin
      // Report restarts with each job reset
      total_cnt  <= '0;
      cmd_cnt    <= '0;
      addr_cnt   <= '0;
      seen       <= 1'b0;
      first_cmd  <= '0;
      first_errs <= '0;
    end else if (rd.pop) begin
      total_cnt <= sat_inc(total_cnt);
      if (rd.errs[1]) begin
        cmd_cnt <= sat_inc(cmd_cnt);
      end
      if (rd.errs[0]) begin
        addr_cnt <= sat_inc(addr_cnt);
      end
      if (!seen) begin
        seen       <= 1'b1;
        first_cmd  <= rd.cmd;
        first_errs <= rd.errs;
      end
    end
  end

  // Report word layout, low 30 bits reserved
  assign report = {total_cnt, first_cmd, first_errs, cmd_cnt, addr_cnt, 30'd0};

endmodule

`default_nettype wire

// File: rtl/job_subsystem.sv
`default_nettype none

module job_subsystem (
  input  logic                clock,
  input  logic                rstn,
  input  logic                job_valid,
  input  job_pkg::job_cmd_t   job_command,
  input  logic                job_command_parity,
  input  job_pkg::job_addr_t  job_address,
  input  logic                job_address_parity,
  output logic                running,
  output logic                done,
  output logic                reset_job,
  output job_pkg::err_bits_t  job_errors,
  output job_pkg::report_t    error
);

  // Record path between the blocks
  err_wr_if err_wr_bus ();
  err_rd_if err_rd_bus ();

  // Report word back to the controller
  job_pkg::report_t report;

  //////////////////////////////////////////////////////////////////////
  // Controller, buffer and reporter
  //////////////////////////////////////////////////////////////////////

  job_control job_control_inst (
    .clock              (clock),
    .rstn               (rstn),
    .job_valid          (job_valid),
    .job_command        (job_command),
    .job_command_parity (job_command_parity),
    .job_address        (job_address),
    .job_address_parity (job_address_parity),
    .report             (report),
    .err_wr             (err_wr_bus),
    .running            (running),
    .done               (done),
    .reset_job          (reset_job),
    .job_errors         (job_errors),
    .error              (error)
  );

  err_fifo err_fifo_inst (
    .clock (clock),
    .rstn  (rstn),
    .wr    (err_wr_bus),
    .rd    (err_rd_bus)
  );

  // Job reset pulse clears the report
  err_reporter err_reporter_inst (
    .clock  (clock),
    .rstn   (rstn),
    .rd     (err_rd_bus),
    .clear  (reset_job),
    .report (report)
  );

endmodule

`default_nettype wire

// File: dv/job_tb.sv
`default_nettype none

`include "job_config.svh"

module job_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic                clock;
  logic                rstn;
  logic                job_valid;
  job_pkg::job_cmd_t   job_command;
  logic                job_command_parity;
  job_pkg::job_addr_t  job_address;
  logic                job_address_parity;
  logic                running;
  logic                done;
  logic                reset_job;
  job_pkg::err_bits_t  job_errors;
  job_pkg::report_t    error;

  // Faults injected with the command on the bus as {cmd, addr}
  job_pkg::err_bits_t  stim_errs;

  // Model pipeline for the E0 capture and the E1 stage
  logic                p1_valid;
  logic                p2_valid;
  job_pkg::job_cmd_t   p1_cmd;
  job_pkg::job_cmd_t   p2_cmd;
  job_pkg::err_bits_t  p1_errs;
  job_pkg::err_bits_t  p2_errs;

  // Expected outputs
  logic                exp_running;
  logic                exp_done;
  logic                exp_reset_job;
  job_pkg::err_bits_t  exp_job_errors;
  job_pkg::report_t    exp_error;

  // Records in flight between E2 and the report update at E5
  logic [2:0]          rec_valid;
  job_pkg::job_cmd_t   rec_cmd  [3];
  job_pkg::err_bits_t  rec_errs [3];

  // Pending report fields since the last job reset
  logic [7:0]          m_total;
  logic [7:0]          m_cmd_cnt;
  logic [7:0]          m_addr_cnt;
  logic                m_seen;
  job_pkg::job_cmd_t   m_first_cmd;
  job_pkg::err_bits_t  m_first_errs;
  job_pkg::report_t    exp_report;

  job_subsystem job_subsystem_inst (
    .clock              (clock),
    .rstn               (rstn),
    .job_valid          (job_valid),
    .job_command        (job_command),
    .job_command_parity (job_command_parity),
    .job_address        (job_address),
    .job_address_parity (job_address_parity),
    .running            (running),
    .done               (done),
    .reset_job          (reset_job),
    .job_errors         (job_errors),
    .error              (error)
  );

  // 10 ns clock
  always #5 clock = ~clock;

  function automatic logic [7:0] add_one_sat(input logic [7:0] v);
    return (v == 8'hFF) ? v : v + 8'd1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Total in 63:56, first command 55:48, first bits 47:46, then cmd and addr counts
  assign exp_report = {m_total, m_first_cmd, m_first_errs, m_cmd_cnt, m_addr_cnt, 30'd0};

  always @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      p1_valid       <= 1'b0;
      p2_valid       <= 1'b0;
      p1_cmd         <= '0;
      p2_cmd         <= '0;
      p1_errs        <= '0;
      p2_errs        <= '0;
      exp_running    <= 1'b0;
      exp_done       <= 1'b0;
      exp_reset_job  <= 1'b0;
      exp_job_errors <= '0;
      exp_error      <= '0;
      rec_valid      <= '0;
      m_total        <= '0;
      m_cmd_cnt      <= '0;
      m_addr_cnt     <= '0;
      m_seen         <= 1'b0;
      m_first_cmd    <= '0;
      m_first_errs   <= '0;
    end else begin
      // E0 and E1
      p1_valid <= job_valid;
      if (job_valid) begin
        p1_cmd  <= job_command;
        p1_errs <= stim_errs;
      end
      p2_valid <= p1_valid;
      p2_cmd   <= p1_cmd;
      p2_errs  <= p1_errs;
      // Flags, running and reset pulse at E2
      exp_reset_job <= 1'b0;
      rec_valid[0]  <= 1'b0;
      if (p2_valid) begin
        exp_job_errors <= p2_errs;
        rec_valid[0]   <= |p2_errs;
        rec_cmd[0]     <= p2_cmd;
        rec_errs[0]    <= p2_errs;
        if (p2_cmd == `JOB_CMD_START) begin
          exp_running <= 1'b1;
        end else if (p2_cmd == `JOB_CMD_RESET) begin
          exp_running   <= 1'b0;
          exp_reset_job <= 1'b1;
        end
      end
      // Done at E3 carries the report from before the clear
      exp_done  <= exp_reset_job;
      exp_error <= exp_reset_job ? exp_report : '0;
      rec_valid[2:1] <= rec_valid[1:0];
      rec_cmd[1]     <= rec_cmd[0];
      rec_cmd[2]     <= rec_cmd[1];
      rec_errs[1]    <= rec_errs[0];
      rec_errs[2]    <= rec_errs[1];
      if (exp_reset_job) begin
        m_total      <= '0;
        m_cmd_cnt    <= '0;
        m_addr_cnt   <= '0;
        m_seen       <= 1'b0;
        m_first_cmd  <= '0;
        m_first_errs <= '0;
      end else if (rec_valid[2]) begin
        // Record reaches the report three edges after E2
        m_total <= add_one_sat(m_total);
        if (rec_errs[2][1]) begin
          m_cmd_cnt <= add_one_sat(m_cmd_cnt);
        end
        if (rec_errs[2][0]) begin
          m_addr_cnt <= add_one_sat(m_addr_cnt);
        end
        if (!m_seen) begin
          m_seen       <= 1'b1;
          m_first_cmd  <= rec_cmd[2];
          m_first_errs <= rec_errs[2];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_on_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] want);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
    $display("Simulation failed");
    $fatal(1);
  endtask

  a_running : assert property (@(posedge clock) disable iff (!rstn) running == exp_running)
    else fail_on_mismatch("running", 64'($sampled(running)), 64'($sampled(exp_running)));
  a_done : assert property (@(posedge clock) disable iff (!rstn) done == exp_done)
    else fail_on_mismatch("done", 64'($sampled(done)), 64'($sampled(exp_done)));
  a_reset_job : assert property (@(posedge clock) disable iff (!rstn)
    reset_job == exp_reset_job)
    else fail_on_mismatch("reset_job", 64'($sampled(reset_job)),
                          64'($sampled(exp_reset_job)));
  a_job_errors : assert property (@(posedge clock) disable iff (!rstn)
    job_errors == exp_job_errors)
    else fail_on_mismatch("job_errors", 64'($sampled(job_errors)),
                          64'($sampled(exp_job_errors)));
  // Error stays zero outside the done pulse
  a_error : assert property (@(posedge clock) disable iff (!rstn) error == exp_error)
    else fail_on_mismatch("error", $sampled(error), $sampled(exp_error));
  // Reporter drains every cycle so the buffer never fills
  a_buffer_room : assert property (@(posedge clock) disable iff (!rstn)
    !job_subsystem_inst.err_wr_bus.full)
    else fail_on_mismatch("err_wr_bus.full",
                          64'($sampled(job_subsystem_inst.err_wr_bus.full)),
                          64'd0);

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic idle(input int n);
    repeat (n) @(negedge clock);
  endtask

  // Called on a falling edge and drives job_valid for one cycle
  task automatic send_cmd(input job_pkg::job_cmd_t cmd, input logic bad_cmd,
                          input logic bad_addr);
    job_pkg::job_addr_t addr;
    addr = {$urandom, $urandom};
    job_valid          = 1'b1;
    job_command        = cmd;
    job_address        = addr;
    // Odd parity bits flipped where a fault is wanted
    job_command_parity = ~^cmd ^ bad_cmd;
    job_address_parity = ~^addr ^ bad_addr;
    stim_errs          = {bad_cmd, bad_addr};
    @(negedge clock);
    job_valid = 1'b0;
  endtask

  task automatic run_cmd(input job_pkg::job_cmd_t cmd, input logic bad_cmd,
                         input logic bad_addr, input int gap);
    send_cmd(cmd, bad_cmd, bad_addr);
    idle(gap - 1);
  endtask

  task automatic wait_for_done(input int limit);
    int cycles;
    cycles = 0;
    while (!done && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!done) begin
      $display("Timed out waiting for the done pulse after a job reset");
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic run_reset(input logic bad_cmd, input logic bad_addr);
    send_cmd(`JOB_CMD_RESET, bad_cmd, bad_addr);
    wait_for_done(10);
    idle(4);
  endtask

  initial begin
    job_pkg::job_cmd_t code;
    logic [1:0]        faults;
    int unsigned       gap;
    clock              = 1'b0;
    rstn               = 1'b0;
    job_valid          = 1'b0;
    job_command        = '0;
    job_command_parity = 1'b0;
    job_address        = '0;
    job_address_parity = 1'b0;
    stim_errs          = '0;
    void'($urandom(77));
    repeat (5) @(negedge clock);
    rstn = 1'b1;
    // Quiet outputs before any command
    idle(6);
    // Clean START followed by a neutral command
    run_cmd(`JOB_CMD_START, 1'b0, 1'b0, 6);
    run_cmd(8'h12, 1'b0, 1'b0, 5);
    // Command, address and double parity faults
    run_cmd(8'h21, 1'b1, 1'b0, 5);
    run_cmd(8'h22, 1'b0, 1'b1, 5);
    run_cmd(8'h23, 1'b1, 1'b1, 5);
    run_reset(1'b0, 1'b0);
    // Faulty RESET shows up in the following report
    run_reset(1'b1, 1'b0);
    run_reset(1'b0, 1'b0);
    // Random codes and faults
    for (int i = 0; i < 20; i++) begin
      code   = job_pkg::job_cmd_t'($urandom);
      faults = 2'($urandom);
      gap    = 4 + $urandom % 5;
      run_cmd(code, faults[1], faults[0], gap);
    end
    run_reset(1'b0, 1'b0);
    // Long run of double faults drives every counter into saturation
    for (int i = 0; i < 260; i++) begin
      run_cmd(8'h45, 1'b1, 1'b1, 4);
    end
    run_reset(1'b0, 1'b0);
    idle(4);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/job_pkg.sv
rtl/err_wr_if.sv
rtl/err_rd_if.sv
rtl/job_control.sv
rtl/err_fifo.sv
rtl/err_reporter.sv
rtl/job_subsystem.sv
dv/job_tb.sv
